//--- dv/tb_rvv_dispatch.sv
// Self-checking testbench for the two-slot vector dispatch stage.
// Applies a table of uop, ROB and ready settings one row per cycle and
// checks strobes, ROB indices and operand data against a reference model.

`timescale 1ns/1ps
`include "rvv_dispatch_defs.svh"

module tb_rvv_dispatch
    import dp_uop_pkg::*;
    import dp_rob_pkg::*;
();

    localparam int NUM_ROWS    = 15;
    localparam int CYCLE_LIMIT = 16 + 4 * NUM_ROWS + 50;

    logic clk;
    logic rst;

    logic      [`NUM_DP_UOP-1:0] uop_valid;
    exe_unit_e [`NUM_DP_UOP-1:0] uop_exe_unit;
    vreg_idx_t [`NUM_DP_UOP-1:0] vs1_index;
    logic      [`NUM_DP_UOP-1:0] vs1_valid;
    vreg_idx_t [`NUM_DP_UOP-1:0] vs2_index;
    logic      [`NUM_DP_UOP-1:0] vs2_valid;
    vreg_idx_t [`NUM_DP_UOP-1:0] vd_index;
    logic      [`NUM_DP_UOP-1:0] vd_valid;
    logic      [`NUM_DP_UOP-1:0] vs3_valid;
    logic      [`NUM_DP_UOP-1:0] uop_ready;
    logic      [`NUM_DP_UOP-1:0] rs_valid_alu;
    logic      [`NUM_DP_UOP-1:0] rs_valid_mul;
    rob_idx_t  [`NUM_DP_UOP-1:0] rs_rob_idx;
    vdata_t    [`NUM_DP_UOP-1:0] rs_vs1_data;
    vdata_t    [`NUM_DP_UOP-1:0] rs_vs2_data;
    vdata_t    [`NUM_DP_UOP-1:0] rs_vd_data;
    logic      [`NUM_DP_UOP-1:0] rs_ready_alu;
    logic      [`NUM_DP_UOP-1:0] rs_ready_mul;
    logic      [`NUM_DP_UOP-1:0] rob_push_valid;
    vreg_idx_t [`NUM_DP_UOP-1:0] rob_vd_index;
    logic      [`NUM_DP_UOP-1:0] rob_vd_valid;
    logic      [`NUM_DP_UOP-1:0] rob_ready;
    rob_idx_t                    rob_alloc_idx;
    logic      [`ROB_DEPTH-1:0]  rob_entry_valid;
    vreg_idx_t [`ROB_DEPTH-1:0]  rob_w_index;
    logic      [`ROB_DEPTH-1:0]  rob_w_valid;
    vdata_t    [`ROB_DEPTH-1:0]  rob_w_data;
    vreg_idx_t [`NUM_DP_VRF-1:0] vrf_rd_index;
    vdata_t    [`NUM_DP_VRF-1:0] vrf_rd_data;

    // Stimulus and expected go bits, bit s of each field belongs to slot s
    logic      [`NUM_DP_UOP-1:0] t_uop_valid [NUM_ROWS];
    exe_unit_e [`NUM_DP_UOP-1:0] t_exe       [NUM_ROWS];
    vreg_idx_t [`NUM_DP_UOP-1:0] t_vs1       [NUM_ROWS];
    logic      [`NUM_DP_UOP-1:0] t_vs1_v     [NUM_ROWS];
    vreg_idx_t [`NUM_DP_UOP-1:0] t_vs2       [NUM_ROWS];
    logic      [`NUM_DP_UOP-1:0] t_vs2_v     [NUM_ROWS];
    vreg_idx_t [`NUM_DP_UOP-1:0] t_vd        [NUM_ROWS];
    logic      [`NUM_DP_UOP-1:0] t_vd_v      [NUM_ROWS];
    logic      [`NUM_DP_UOP-1:0] t_vs3_v     [NUM_ROWS];
    logic      [`ROB_DEPTH-1:0]  t_ev        [NUM_ROWS];
    vreg_idx_t [`ROB_DEPTH-1:0]  t_wi        [NUM_ROWS];
    logic      [`ROB_DEPTH-1:0]  t_wv        [NUM_ROWS];
    vdata_t    [`ROB_DEPTH-1:0]  t_wd        [NUM_ROWS];
    logic      [`NUM_DP_UOP-1:0] t_rdy_alu   [NUM_ROWS];
    logic      [`NUM_DP_UOP-1:0] t_rdy_mul   [NUM_ROWS];
    logic      [`NUM_DP_UOP-1:0] t_rdy_rob   [NUM_ROWS];
    rob_idx_t                    t_alloc     [NUM_ROWS];
    logic      [`NUM_DP_UOP-1:0] t_go        [NUM_ROWS];

    integer seed;
    int     errors;
    int     checks;
    int     cycles;

    rvv_dispatch DUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // VRF model, the word is the register index replicated per byte
    function automatic vdata_t vrf_value(input vreg_idx_t idx);
        return vdata_t'({4{3'b000, idx}});
    endfunction

    always_comb begin
        for (int p = 0; p < `NUM_DP_VRF; p++) begin
            vrf_rd_data[p] = vrf_value(vrf_rd_index[p]);
        end
    end

    // Youngest valid writer of idx decides, no writer means VRF data
    function automatic vdata_t expected_operand(input int r, input vreg_idx_t idx);
        vdata_t val;
        logic   found;
        val   = vrf_value(idx);
        found = 1'b0;
        for (int e = `ROB_DEPTH - 1; e >= 0; e--) begin
            if (!found && t_ev[r][e] && (t_wi[r][e] == idx)) begin
                found = 1'b1;
                if (t_wv[r][e]) begin
                    val = t_wd[r][e];
                end
            end
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
        end
    endtask

    task automatic clear_row(input int r);
        t_uop_valid[r] = '0;
        t_exe[r][0]    = EXE_ALU;
        t_exe[r][1]    = EXE_ALU;
        t_vs1[r]       = '0;
        t_vs1_v[r]     = '0;
        t_vs2[r]       = '0;
        t_vs2_v[r]     = '0;
        t_vd[r]        = '0;
        t_vd_v[r]      = '0;
        t_vs3_v[r]     = '0;
        t_ev[r]        = '0;
        t_wi[r]        = '0;
        t_wv[r]        = '0;
        t_rdy_alu[r]   = 2'b11;
        t_rdy_mul[r]   = 2'b11;
        t_rdy_rob[r]   = 2'b11;
        t_alloc[r]     = '0;
        t_go[r]        = '0;
        for (int e = 0; e < `ROB_DEPTH; e++) begin
            t_wd[r][e] = $random(seed);
        end
    endtask

    task automatic set_uop(input int r, input int s, input exe_unit_e exe,
                           input vreg_idx_t vs1, input logic vs1v,
                           input vreg_idx_t vs2, input logic vs2v,
                           input vreg_idx_t vd, input logic vdv, input logic vs3v);
        t_uop_valid[r][s] = 1'b1;
        t_exe[r][s]       = exe;
        t_vs1[r][s]       = vs1;
        t_vs1_v[r][s]     = vs1v;
        t_vs2[r][s]       = vs2;
        t_vs2_v[r][s]     = vs2v;
        t_vd[r][s]        = vd;
        t_vd_v[r][s]      = vdv;
        t_vs3_v[r][s]     = vs3v;
    endtask

    task automatic set_rob(input int r, input int e, input vreg_idx_t idx, input logic has_data);
        t_ev[r][e] = 1'b1;
        t_wi[r][e] = idx;
        t_wv[r][e] = has_data;
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            clear_row(r);
        end
        // Four reads on separate ports, no ROB match
        set_uop(0, 0, EXE_ALU, 1, 1, 2, 1, 5, 1, 0);
        set_uop(0, 1, EXE_ALU, 3, 1, 4, 1, 6, 1, 0);
        t_go[0] = 2'b11;
        // Forwarding, entry 5 is younger than entry 2
        set_rob(1, 2, 1, 1);
        set_rob(1, 5, 1, 1);
        set_rob(1, 3, 4, 1);
        set_uop(1, 0, EXE_ALU, 1, 1, 2, 1, 7, 1, 0);
        set_uop(1, 1, EXE_MUL, 3, 1, 4, 1, 8, 1, 0);
        t_alloc[1] = 3'd3;
        t_go[1]    = 2'b11;
        // Pending writer blocks slot 0 and with it slot 1
        set_rob(2, 4, 2, 0);
        set_uop(2, 0, EXE_ALU, 1, 1, 2, 1, 7, 1, 0);
        set_uop(2, 1, EXE_ALU, 3, 1, 4, 1, 8, 1, 0);
        // Youngest match wins in both directions
        set_rob(3, 1, 7, 0);
        set_rob(3, 6, 7, 1);
        set_rob(3, 0, 8, 1);
        set_rob(3, 7, 8, 0);
        set_uop(3, 0, EXE_ALU, 7, 1, 2, 1, 9, 1, 0);
        set_uop(3, 1, EXE_ALU, 3, 1, 8, 1, 10, 1, 0);
        t_go[3] = 2'b01;
        // Inter-uop RAW through vs1, then through vd as a source
        set_uop(4, 0, EXE_ALU, 1, 1, 2, 1, 10, 1, 0);
        set_uop(4, 1, EXE_ALU, 10, 1, 4, 1, 11, 1, 0);
        t_go[4] = 2'b01;
        set_uop(5, 0, EXE_ALU, 0, 0, 2, 1, 11, 1, 0);
        set_uop(5, 1, EXE_ALU, 0, 0, 4, 1, 11, 1, 1);
        t_go[5] = 2'b01;
        // No RAW when uop 0 does not write vd
        set_uop(6, 0, EXE_ALU, 1, 1, 2, 1, 12, 0, 0);
        set_uop(6, 1, EXE_ALU, 3, 1, 12, 1, 13, 1, 0);
        t_go[6] = 2'b11;
        // Five reads, then two reads that share port 1
        set_uop(7, 0, EXE_ALU, 1, 1, 2, 1, 14, 1, 1);
        set_uop(7, 1, EXE_ALU, 3, 1, 4, 1, 15, 1, 0);
        t_go[7] = 2'b01;
        set_uop(8, 0, EXE_ALU, 1, 1, 2, 0, 16, 1, 0);
        set_uop(8, 1, EXE_ALU, 3, 0, 4, 0, 17, 1, 1);
        t_go[8] = 2'b01;
        // Four reads with vd on both slots, no shared port
        set_uop(9, 0, EXE_ALU, 1, 0, 2, 1, 20, 1, 1);
        set_uop(9, 1, EXE_ALU, 3, 0, 22, 1, 21, 1, 1);
        t_go[9] = 2'b11;
        // Back-pressure on slot 0 from its RS, then from the ROB
        for (int r = 10; r <= 12; r++) begin
            set_uop(r, 0, EXE_ALU, 1, 1, 2, 1, 5, 1, 0);
            set_uop(r, 1, EXE_ALU, 3, 1, 4, 1, 6, 1, 0);
        end
        t_exe[10][0]  = EXE_MUL;
        t_rdy_mul[10] = 2'b10;
        t_rdy_rob[11] = 2'b10;
        // Back-pressure on slot 1 only
        t_rdy_alu[12] = 2'b01;
        t_go[12]      = 2'b01;
        // ROB index wraps, slot 0 ignores its ALU ready
        set_uop(13, 0, EXE_MUL, 1, 1, 2, 1, 5, 1, 0);
        set_uop(13, 1, EXE_ALU, 3, 1, 4, 1, 6, 1, 0);
        t_alloc[13]   = 3'd7;
        t_rdy_alu[13] = 2'b10;
        t_go[13]      = 2'b11;
        // Lone uop in slot 0
        set_uop(14, 0, EXE_MUL, 9, 1, 10, 1, 11, 1, 0);
        t_rdy_rob[14] = 2'b01;
        t_go[14]      = 2'b01;
    endtask

    task automatic apply_row(input int r);
        uop_valid       = t_uop_valid[r];
        uop_exe_unit    = t_exe[r];
        vs1_index       = t_vs1[r];
        vs1_valid       = t_vs1_v[r];
        vs2_index       = t_vs2[r];
        vs2_valid       = t_vs2_v[r];
        vd_index        = t_vd[r];
        vd_valid        = t_vd_v[r];
        vs3_valid       = t_vs3_v[r];
        rob_entry_valid = t_ev[r];
        rob_w_index     = t_wi[r];
        rob_w_valid     = t_wv[r];
        rob_w_data      = t_wd[r];
        rs_ready_alu    = t_rdy_alu[r];
        rs_ready_mul    = t_rdy_mul[r];
        rob_ready       = t_rdy_rob[r];
        rob_alloc_idx   = t_alloc[r];
    endtask

    task automatic check_row(input int r);
        logic go;
        int   vs1_port;
        int   vs2_port;
        int   vd_port;
        for (int s = 0; s < `NUM_DP_UOP; s++) begin
            go = t_go[r][s];
            // Fixed VRF port map, slot 1 gets the ports slot 0 leaves free
            vs2_port = (s == 0) ? 0 : 2;
            vs1_port = (s == 0) ? 1 : 3;
            vd_port  = (s == 0) ? 3 : 1;
            check_value($sformatf("uop_ready[%0d]", s), uop_ready[s], go);
            check_value($sformatf("rob_push_valid[%0d]", s), rob_push_valid[s], go);
            check_value($sformatf("rs_valid_alu[%0d]", s), rs_valid_alu[s],
                        go && (t_exe[r][s] == EXE_ALU));
            check_value($sformatf("rs_valid_mul[%0d]", s), rs_valid_mul[s],
                        go && (t_exe[r][s] == EXE_MUL));
            check_value($sformatf("rob_vd_index[%0d]", s), rob_vd_index[s], t_vd[r][s]);
            check_value($sformatf("rob_vd_valid[%0d]", s), rob_vd_valid[s], t_vd_v[r][s]);
            if (go) begin
                check_value($sformatf("rs_rob_idx[%0d]", s), rs_rob_idx[s],
                            (int'(t_alloc[r]) + s) % `ROB_DEPTH);
                if (t_vs1_v[r][s]) begin
                    check_value($sformatf("vrf_rd_index[%0d]", vs1_port),
                                vrf_rd_index[vs1_port], t_vs1[r][s]);
                    check_value($sformatf("rs_vs1_data[%0d]", s), rs_vs1_data[s],
                                expected_operand(r, t_vs1[r][s]));
                end
                if (t_vs2_v[r][s]) begin
                    check_value($sformatf("vrf_rd_index[%0d]", vs2_port),
                                vrf_rd_index[vs2_port], t_vs2[r][s]);
                    check_value($sformatf("rs_vs2_data[%0d]", s), rs_vs2_data[s],
                                expected_operand(r, t_vs2[r][s]));
                end
                if (t_vs3_v[r][s]) begin
                    check_value($sformatf("vrf_rd_index[%0d]", vd_port),
                                vrf_rd_index[vd_port], t_vd[r][s]);
                    check_value($sformatf("rs_vd_data[%0d]", s), rs_vd_data[s],
                                expected_operand(r, t_vd[r][s]));
                end
            end
        end
    endtask

    // Guard against a stuck run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        seed   = 24;
        errors = 0;
        checks = 0;
        cycles = 0;
        rst    = 1'b1;
        // Idle inputs, all valids low
        clear_row(0);
        apply_row(0);
        rs_ready_alu = '0;
        rs_ready_mul = '0;
        rob_ready    = '0;
        build_table();
        repeat (16) begin
            @(negedge clk);
            check_value("uop_ready", uop_ready, '0);
            check_value("rs_valid_alu", rs_valid_alu, '0);
            check_value("rs_valid_mul", rs_valid_mul, '0);
            check_value("rob_push_valid", rob_push_valid, '0);
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            #1;
            apply_row(r);
            @(negedge clk);
            check_row(r);
        end
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- rvv_dispatch.f
+incdir+src
src/dp_uop_pkg.sv
src/dp_rob_pkg.sv
src/dp_read_arbiter.sv
src/dp_operand_resolve.sv
src/dp_issue_ctrl.sv
src/rvv_dispatch.sv
dv/tb_rvv_dispatch.sv

//--- src/dp_issue_ctrl.sv
// In-order issue control for the dispatch stage.
// Decides which slots go this cycle, drives the queue, RS and ROB
// strobes and fans the resolved payload out to the RS buses.

`timescale 1ns/1ps
`include "rvv_dispatch_defs.svh"

module dp_issue_ctrl
    import dp_uop_pkg::*;
    import dp_rob_pkg::*;
(
    input  logic      [`NUM_DP_UOP-1:0] uop_valid,
    input  exe_unit_e [`NUM_DP_UOP-1:0] uop_exe_unit,
    input  vreg_idx_t [`NUM_DP_UOP-1:0] vs1_index,
    input  logic      [`NUM_DP_UOP-1:0] vs1_valid,
    input  vreg_idx_t [`NUM_DP_UOP-1:0] vs2_index,
    input  logic      [`NUM_DP_UOP-1:0] vs2_valid,
    input  vreg_idx_t [`NUM_DP_UOP-1:0] vd_index,
    input  logic      [`NUM_DP_UOP-1:0] vd_valid,
    input  logic      [`NUM_DP_UOP-1:0] vs3_valid,
    input  logic      [`NUM_DP_UOP-1:0] raw_wait,
    input  logic                        strct_hazard,
    input  logic      [`NUM_DP_UOP-1:0] rs_ready_alu,
    input  logic      [`NUM_DP_UOP-1:0] rs_ready_mul,
    input  logic      [`NUM_DP_UOP-1:0] rob_ready,
    input  rob_idx_t                    rob_alloc_idx,
    input  vdata_t    [`NUM_DP_UOP-1:0] opnd_vs1_data,
    input  vdata_t    [`NUM_DP_UOP-1:0] opnd_vs2_data,
    input  vdata_t    [`NUM_DP_UOP-1:0] opnd_vd_data,
    output logic      [`NUM_DP_UOP-1:0] uop_ready,
    output logic      [`NUM_DP_UOP-1:0] rs_valid_alu,
    output logic      [`NUM_DP_UOP-1:0] rs_valid_mul,
    output logic      [`NUM_DP_UOP-1:0] rob_push_valid,
    output rob_idx_t  [`NUM_DP_UOP-1:0] rs_rob_idx,
    output vdata_t    [`NUM_DP_UOP-1:0] rs_vs1_data,
    output vdata_t    [`NUM_DP_UOP-1:0] rs_vs2_data,
    output vdata_t    [`NUM_DP_UOP-1:0] rs_vd_data,
    output vreg_idx_t [`NUM_DP_UOP-1:0] rob_vd_index,
    output logic      [`NUM_DP_UOP-1:0] rob_vd_valid
);

    logic                   uop_raw;
    logic [`NUM_DP_UOP-1:0] rs_ok;
    logic [`NUM_DP_UOP-1:0] slot_ok;
    logic [`NUM_DP_UOP-1:0] go;

    // uop 1 reads the register that uop 0 is about to write
    assign uop_raw = uop_valid[0] & vd_valid[0] &
                     ((vs1_valid[1] & (vs1_index[1] == vd_index[0])) |
                      (vs2_valid[1] & (vs2_index[1] == vd_index[0])) |
                      (vs3_valid[1] & (vd_index[1] == vd_index[0])));

    always_comb begin
        for (int s = 0; s < `NUM_DP_UOP; s++) begin
            rs_ok[s]   = (uop_exe_unit[s] == EXE_MUL) ? rs_ready_mul[s] : rs_ready_alu[s];
            slot_ok[s] = uop_valid[s] & ~raw_wait[s] & rob_ready[s] & rs_ok[s];
        end
    end

    // Strictly in order, a younger slot never passes an older one
    assign go[0] = slot_ok[0];
    assign go[1] = slot_ok[1] & go[0] & ~uop_raw & ~strct_hazard;

    always_comb begin
        for (int s = 0; s < `NUM_DP_UOP; s++) begin
            uop_ready[s]      = go[s];
            rob_push_valid[s] = go[s];
            rs_valid_alu[s]   = go[s] & (uop_exe_unit[s] == EXE_ALU);
            rs_valid_mul[s]   = go[s] & (uop_exe_unit[s] == EXE_MUL);
        end
    end

    // Payload is shared by both RS buses and not gated by go
    always_comb begin
        int unsigned slot_idx;
        for (int s = 0; s < `NUM_DP_UOP; s++) begin
            slot_idx = int'(rob_alloc_idx) + s;
            if (slot_idx >= `ROB_DEPTH) begin
                slot_idx = slot_idx - `ROB_DEPTH;
            end
            rs_rob_idx[s]   = rob_idx_t'(slot_idx);
            rs_vs1_data[s]  = opnd_vs1_data[s];
            rs_vs2_data[s]  = opnd_vs2_data[s];
            rs_vd_data[s]   = opnd_vd_data[s];
            rob_vd_index[s] = vd_index[s];
            rob_vd_valid[s] = vd_valid[s];
        end
    end

endmodule

//--- src/dp_operand_resolve.sv
// Operand resolution for one dispatch slot.
// Checks each source against the ROB, forwards data from the youngest
// matching entry and raises raw_wait when that entry has no data yet.

`timescale 1ns/1ps
`include "rvv_dispatch_defs.svh"

module dp_operand_resolve
    import dp_uop_pkg::*;
    import dp_rob_pkg::*;
(
    input  vreg_idx_t                  vs1_index,
    input  logic                       vs1_valid,
    input  vreg_idx_t                  vs2_index,
    input  logic                       vs2_valid,
    input  vreg_idx_t                  vd_index,
    input  logic                       vs3_valid,
    input  vdata_t                     vrf_vs1_data,
    input  vdata_t                     vrf_vs2_data,
    input  vdata_t                     vrf_vd_data,
    input  logic      [`ROB_DEPTH-1:0] rob_entry_valid,
    input  vreg_idx_t [`ROB_DEPTH-1:0] rob_w_index,
    input  logic      [`ROB_DEPTH-1:0] rob_w_valid,
    input  vdata_t    [`ROB_DEPTH-1:0] rob_w_data,
    output vdata_t                     vs1_data,
    output vdata_t                     vs2_data,
    output vdata_t                     vd_data,
    output logic                       raw_wait
);

    opnd_src_e vs1_src;
    opnd_src_e vs2_src;
    opnd_src_e vd_src;
    rob_idx_t  vs1_hit;
    rob_idx_t  vs2_hit;
    rob_idx_t  vd_hit;

    // Scan from oldest to youngest so the last match wins
    function automatic opnd_src_e find_src(
        input  vreg_idx_t idx,
        input  logic      rd_en,
        output rob_idx_t  hit_idx
    );
        opnd_src_e src;
        src     = SRC_VRF;
        hit_idx = '0;
        for (int e = 0; e < `ROB_DEPTH; e++) begin
            if (rd_en && rob_entry_valid[e] && (rob_w_index[e] == idx)) begin
                hit_idx = rob_idx_t'(e);
                src     = rob_w_valid[e] ? SRC_ROB : SRC_WAIT;
            end
        end
        return src;
    endfunction

    always_comb begin
        vs1_src = find_src(vs1_index, vs1_valid, vs1_hit);
        vs2_src = find_src(vs2_index, vs2_valid, vs2_hit);
        vd_src  = find_src(vd_index, vs3_valid, vd_hit);
    end

    // A pending writer without data stalls the whole slot
    assign raw_wait = (vs1_src == SRC_WAIT) | (vs2_src == SRC_WAIT) | (vd_src == SRC_WAIT);

    assign vs1_data = (vs1_src == SRC_ROB) ? rob_w_data[vs1_hit] : vrf_vs1_data;
    assign vs2_data = (vs2_src == SRC_ROB) ? rob_w_data[vs2_hit] : vrf_vs2_data;
    assign vd_data  = (vd_src == SRC_ROB) ? rob_w_data[vd_hit] : vrf_vd_data;

endmodule

//--- src/dp_read_arbiter.sv
// VRF read-port arbiter for the two dispatch slots.
// Maps operand reads onto the four ports, routes the read data back
// and flags a structure hazard that holds back slot 1.

`timescale 1ns/1ps
`include "rvv_dispatch_defs.svh"

module dp_read_arbiter
    import dp_uop_pkg::*;
    import dp_rob_pkg::*;
(
    input  logic      [`NUM_DP_UOP-1:0] uop_valid,
    input  vreg_idx_t [`NUM_DP_UOP-1:0] vs1_index,
    input  logic      [`NUM_DP_UOP-1:0] vs1_valid,
    input  vreg_idx_t [`NUM_DP_UOP-1:0] vs2_index,
    input  logic      [`NUM_DP_UOP-1:0] vs2_valid,
    input  vreg_idx_t [`NUM_DP_UOP-1:0] vd_index,
    input  logic      [`NUM_DP_UOP-1:0] vs3_valid,
    output vreg_idx_t [`NUM_DP_VRF-1:0] vrf_rd_index,
    input  vdata_t    [`NUM_DP_VRF-1:0] vrf_rd_data,
    output vdata_t    [`NUM_DP_UOP-1:0] vrf_vs1_data,
    output vdata_t    [`NUM_DP_UOP-1:0] vrf_vs2_data,
    output vdata_t    [`NUM_DP_UOP-1:0] vrf_vd_data,
    output logic                        strct_hazard
);

    // Per slot read requests, only counted for a valid uop
    logic [`NUM_DP_UOP-1:0] need_vs1;
    logic [`NUM_DP_UOP-1:0] need_vs2;
    logic [`NUM_DP_UOP-1:0] need_vd;
    logic [2:0]             rd_cnt;
    logic                   port_clash;

    assign need_vs1 = uop_valid & vs1_valid;
    assign need_vs2 = uop_valid & vs2_valid;
    assign need_vd  = uop_valid & vs3_valid;

    always_comb begin
        rd_cnt = '0;
        for (int s = 0; s < `NUM_DP_UOP; s++) begin
            rd_cnt = rd_cnt + 3'(need_vs1[s]) + 3'(need_vs2[s]) + 3'(need_vd[s]);
        end
    end

    // Ports 1 and 3 are shared, slot 0 has priority on both
    assign port_clash = (need_vs1[0] & need_vd[1]) | (need_vd[0] & need_vs1[1]);

    assign strct_hazard = uop_valid[1] & ((rd_cnt > 3'd4) | port_clash);

    // Fixed port map
    //   port 0 : slot0 vs2
    //   port 1 : slot0 vs1, else slot1 vd
    //   port 2 : slot1 vs2
    //   port 3 : slot0 vd,  else slot1 vs1
    assign vrf_rd_index[0] = vs2_index[0];
    assign vrf_rd_index[1] = need_vs1[0] ? vs1_index[0] : vd_index[1];
    assign vrf_rd_index[2] = vs2_index[1];
    assign vrf_rd_index[3] = need_vd[0] ? vd_index[0] : vs1_index[1];

    // Data comes back on the same ports in the same cycle
    assign vrf_vs2_data[0] = vrf_rd_data[0];
    assign vrf_vs1_data[0] = vrf_rd_data[1];
    assign vrf_vd_data[0]  = vrf_rd_data[3];

    // Slot 1 data is only meaningful when no structure hazard is flagged
    assign vrf_vs2_data[1] = vrf_rd_data[2];
    assign vrf_vs1_data[1] = vrf_rd_data[3];
    assign vrf_vd_data[1]  = vrf_rd_data[1];

endmodule

//--- src/dp_rob_pkg.sv
// Types for ROB entries and operand data seen by dispatch.

`include "rvv_dispatch_defs.svh"

package dp_rob_pkg;

    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    typedef logic [`VLEN-1:0] vdata_t;

    // Where an operand comes from this cycle
    typedef enum logic [1:0] {
        SRC_VRF  = 2'd0,
        SRC_ROB  = 2'd1,
        SRC_WAIT = 2'd2
    } opnd_src_e;

endpackage

//--- src/dp_uop_pkg.sv
// Types that describe a uop as it leaves the uop queue.
// Import into any block that handles uop fields.

`include "rvv_dispatch_defs.svh"

package dp_uop_pkg;

    // Reservation station a uop is steered to
    typedef enum logic [0:0] {
        EXE_ALU = 1'b0,
        EXE_MUL = 1'b1
    } exe_unit_e;

    // Architectural vector register number
    typedef logic [`VREG_IDX_W-1:0] vreg_idx_t;

endpackage

//--- src/rvv_dispatch.sv
// Two-slot vector uop dispatch stage, fully combinational.
// Takes up to two in-order uops from the uop queue, resolves their
// operands from the VRF or the ROB and issues them to the ALU/MUL RS
// and the ROB in the same cycle.

`timescale 1ns/1ps
`include "rvv_dispatch_defs.svh"

module rvv_dispatch
    import dp_uop_pkg::*;
    import dp_rob_pkg::*;
(
    // Uop queue
    input  logic      [`NUM_DP_UOP-1:0] uop_valid,
    input  exe_unit_e [`NUM_DP_UOP-1:0] uop_exe_unit,
    input  vreg_idx_t [`NUM_DP_UOP-1:0] vs1_index,
    input  logic      [`NUM_DP_UOP-1:0] vs1_valid,
    input  vreg_idx_t [`NUM_DP_UOP-1:0] vs2_index,
    input  logic      [`NUM_DP_UOP-1:0] vs2_valid,
    input  vreg_idx_t [`NUM_DP_UOP-1:0] vd_index,
    input  logic      [`NUM_DP_UOP-1:0] vd_valid,
    input  logic      [`NUM_DP_UOP-1:0] vs3_valid,
    output logic      [`NUM_DP_UOP-1:0] uop_ready,

    // ALU and MUL reservation stations
    output logic      [`NUM_DP_UOP-1:0] rs_valid_alu,
    output logic      [`NUM_DP_UOP-1:0] rs_valid_mul,
    output rob_idx_t  [`NUM_DP_UOP-1:0] rs_rob_idx,
    output vdata_t    [`NUM_DP_UOP-1:0] rs_vs1_data,
    output vdata_t    [`NUM_DP_UOP-1:0] rs_vs2_data,
    output vdata_t    [`NUM_DP_UOP-1:0] rs_vd_data,
    input  logic      [`NUM_DP_UOP-1:0] rs_ready_alu,
    input  logic      [`NUM_DP_UOP-1:0] rs_ready_mul,

    // ROB push
    output logic      [`NUM_DP_UOP-1:0] rob_push_valid,
    output vreg_idx_t [`NUM_DP_UOP-1:0] rob_vd_index,
    output logic      [`NUM_DP_UOP-1:0] rob_vd_valid,
    input  logic      [`NUM_DP_UOP-1:0] rob_ready,
    input  rob_idx_t                    rob_alloc_idx,

    // ROB entries for hazard check and forwarding, highest is youngest
    input  logic      [`ROB_DEPTH-1:0]  rob_entry_valid,
    input  vreg_idx_t [`ROB_DEPTH-1:0]  rob_w_index,
    input  logic      [`ROB_DEPTH-1:0]  rob_w_valid,
    input  vdata_t    [`ROB_DEPTH-1:0]  rob_w_data,

    // VRF read ports, data returns in the same cycle
    output vreg_idx_t [`NUM_DP_VRF-1:0] vrf_rd_index,
    input  vdata_t    [`NUM_DP_VRF-1:0] vrf_rd_data
);

    vdata_t [`NUM_DP_UOP-1:0] vrf_vs1_data;
    vdata_t [`NUM_DP_UOP-1:0] vrf_vs2_data;
    vdata_t [`NUM_DP_UOP-1:0] vrf_vd_data;
    logic                     strct_hazard;

    vdata_t [`NUM_DP_UOP-1:0] opnd_vs1_data;
    vdata_t [`NUM_DP_UOP-1:0] opnd_vs2_data;
    vdata_t [`NUM_DP_UOP-1:0] opnd_vd_data;
    logic   [`NUM_DP_UOP-1:0] raw_wait;

    dp_read_arbiter u_read_arbiter (
        .uop_valid    (uop_valid),
        .vs1_index    (vs1_index),
        .vs1_valid    (vs1_valid),
        .vs2_index    (vs2_index),
        .vs2_valid    (vs2_valid),
        .vd_index     (vd_index),
        .vs3_valid    (vs3_valid),
        .vrf_rd_index (vrf_rd_index),
        .vrf_rd_data  (vrf_rd_data),
        .vrf_vs1_data (vrf_vs1_data),
        .vrf_vs2_data (vrf_vs2_data),
        .vrf_vd_data  (vrf_vd_data),
        .strct_hazard (strct_hazard)
    );

    // One resolver per slot, each sees the full ROB
    genvar i;
    generate
        for (i = 0; i < `NUM_DP_UOP; i++) begin : gen_resolve
            dp_operand_resolve u_operand_resolve (
                .vs1_index       (vs1_index[i]),
                .vs1_valid       (vs1_valid[i]),
                .vs2_index       (vs2_index[i]),
                .vs2_valid       (vs2_valid[i]),
                .vd_index        (vd_index[i]),
                .vs3_valid       (vs3_valid[i]),
                .vrf_vs1_data    (vrf_vs1_data[i]),
                .vrf_vs2_data    (vrf_vs2_data[i]),
                .vrf_vd_data     (vrf_vd_data[i]),
                .rob_entry_valid (rob_entry_valid),
                .rob_w_index     (rob_w_index),
                .rob_w_valid     (rob_w_valid),
                .rob_w_data      (rob_w_data),
                .vs1_data        (opnd_vs1_data[i]),
                .vs2_data        (opnd_vs2_data[i]),
                .vd_data         (opnd_vd_data[i]),
                .raw_wait        (raw_wait[i])
            );
        end
    endgenerate

    dp_issue_ctrl u_issue_ctrl (
        .uop_valid      (uop_valid),
        .uop_exe_unit   (uop_exe_unit),
        .vs1_index      (vs1_index),
        .vs1_valid      (vs1_valid),
        .vs2_index      (vs2_index),
        .vs2_valid      (vs2_valid),
        .vd_index       (vd_index),
        .vd_valid       (vd_valid),
        .vs3_valid      (vs3_valid),
        .raw_wait       (raw_wait),
        .strct_hazard   (strct_hazard),
        .rs_ready_alu   (rs_ready_alu),
        .rs_ready_mul   (rs_ready_mul),
        .rob_ready      (rob_ready),
        .rob_alloc_idx  (rob_alloc_idx),
        .opnd_vs1_data  (opnd_vs1_data),
        .opnd_vs2_data  (opnd_vs2_data),
        .opnd_vd_data   (opnd_vd_data),
        .uop_ready      (uop_ready),
        .rs_valid_alu   (rs_valid_alu),
        .rs_valid_mul   (rs_valid_mul),
        .rob_push_valid (rob_push_valid),
        .rs_rob_idx     (rs_rob_idx),
        .rs_vs1_data    (rs_vs1_data),
        .rs_vs2_data    (rs_vs2_data),
        .rs_vd_data     (rs_vd_data),
        .rob_vd_index   (rob_vd_index),
        .rob_vd_valid   (rob_vd_valid)
    );

endmodule

//--- src/rvv_dispatch_defs.svh
// Sizing macros shared by the vector dispatch stage and its packages.
// Include wherever a width or a count is needed.

`ifndef RVV_DISPATCH_DEFS_SVH
`define RVV_DISPATCH_DEFS_SVH

// Uops looked at per cycle, slot 0 is the older one
`define NUM_DP_UOP 2

// ROB entries visible to dispatch
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// Vector register index width
`define VREG_IDX_W 5

// Operand width, kept small for simulation
`define VLEN 32

// VRF read ports available to dispatch
`define NUM_DP_VRF 4

`endif
